// File: sources.f
+incdir+.
vec_cfg_pkg.sv
vec_ctrl_pkg.sv
lane_alu.sv
vec_execute_stage.sv
vec_load_queue.sv
vec_writeback.sv
vec_dpath_top.sv
tb_vec_dpath.sv

// File: tb_vec_dpath_cases.svh
// Case table entry type, response pattern and the stimulus table
// for the vector datapath testbench

`ifndef TB_VEC_DPATH_CASES_SVH
`define TB_VEC_DPATH_CASES_SVH

// Lanes 3..0 mix positive and negative bytes and halfwords
localparam lane_vec_t LOAD_PATTERN = 128'h12348081_0000ff7f_a5a57f80_8000ffff;

// One operation, with the field of each stage it passes through
typedef struct packed {
  op0_sel_e         op0_sel;
  op1_sel_e         op1_sel;
  logic [IDX_W-1:0] v_idx;
  alu_fn_e          alu_fn;
  load_fn_e         load_fn;
  wb_sel_e          wb_sel;
  lane_vec_t        resp;
  logic [3:0]       stall_cycles;
  // Number of operations issued back to back from this entry
  logic [1:0]       group;
} case_t;

case_t cases[$];
string case_name[$];

task automatic add_case(input string name, input op0_sel_e s0, input op1_sel_e s1,
                        input logic [IDX_W-1:0] idx, input alu_fn_e fn,
                        input load_fn_e lfn, input wb_sel_e wsel, input lane_vec_t resp,
                        input int stall_n, input int group);
  case_t c;
  c.op0_sel      = s0;
  c.op1_sel      = s1;
  c.v_idx        = idx;
  c.alu_fn       = fn;
  c.load_fn      = lfn;
  c.wb_sel       = wsel;
  c.resp         = resp;
  c.stall_cycles = 4'(stall_n);
  c.group        = 2'(group);
  cases.push_back(c);
  case_name.push_back(name);
endtask

task automatic load_cases();
  // Lane functions on two vector operands
  add_case("alu_add", OP0_VREG, OP1_VREG, 4'd0, ALU_ADD, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_sub", OP0_VREG, OP1_VREG, 4'd0, ALU_SUB, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_and", OP0_VREG, OP1_VREG, 4'd0, ALU_AND, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_or", OP0_VREG, OP1_VREG, 4'd0, ALU_OR, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_xor", OP0_VREG, OP1_VREG, 4'd0, ALU_XOR, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_slt", OP0_VREG, OP1_VREG, 4'd0, ALU_SLT, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_sltu", OP0_VREG, OP1_VREG, 4'd0, ALU_SLTU, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_sll", OP0_VREG, OP1_VREG, 4'd0, ALU_SLL, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_srl", OP0_VREG, OP1_VREG, 4'd0, ALU_SRL, LD_W, WB_ALU, '0, 0, 1);
  add_case("alu_sra", OP0_VREG, OP1_VREG, 4'd0, ALU_SRA, LD_W, WB_ALU, '0, 0, 1);
  // Scalar broadcast and zero operands
  add_case("scalar_zero", OP0_SCALAR, OP1_ZERO, 4'd0, ALU_ADD, LD_W, WB_ALU, '0, 0, 1);
  add_case("scalar_sub", OP0_SCALAR, OP1_VREG, 4'd0, ALU_SUB, LD_W, WB_ALU, '0, 0, 1);
  add_case("zero_or", OP0_ZERO, OP1_VREG, 4'd0, ALU_OR, LD_W, WB_ALU, '0, 0, 1);
  // Strided addresses
  add_case("stride_5", OP0_SCALAR, OP1_STRIDE, 4'd5, ALU_ADD, LD_W, WB_ALU, '0, 0, 1);
  add_case("stride_15", OP0_SCALAR, OP1_STRIDE, 4'd15, ALU_ADD, LD_W, WB_ALU, '0, 0, 1);
  // Load adjustment
  add_case("load_w", OP0_SCALAR, OP1_STRIDE, 4'd1, ALU_ADD, LD_W, WB_LOAD, LOAD_PATTERN, 0, 1);
  add_case("load_b", OP0_SCALAR, OP1_STRIDE, 4'd2, ALU_ADD, LD_B, WB_LOAD, LOAD_PATTERN, 0, 1);
  add_case("load_bu", OP0_SCALAR, OP1_STRIDE, 4'd3, ALU_ADD, LD_BU, WB_LOAD, LOAD_PATTERN, 0, 1);
  add_case("load_h", OP0_SCALAR, OP1_STRIDE, 4'd4, ALU_ADD, LD_H, WB_LOAD, LOAD_PATTERN, 0, 1);
  add_case("load_hu", OP0_SCALAR, OP1_STRIDE, 4'd6, ALU_ADD, LD_HU, WB_LOAD, LOAD_PATTERN, 0, 1);
  // Response held through a stall, two operations queued up behind it
  add_case("queued_h", OP0_SCALAR, OP1_STRIDE, 4'd7, ALU_ADD, LD_H, WB_LOAD, LOAD_PATTERN, 3, 3);
  add_case("stall_xor", OP0_VREG, OP1_VREG, 4'd0, ALU_XOR, LD_W, WB_ALU, '0, 0, 0);
  add_case("stall_sll", OP0_VREG, OP1_VREG, 4'd0, ALU_SLL, LD_W, WB_ALU, '0, 0, 0);
  // Three operations in flight
  add_case("pipe_sub", OP0_VREG, OP1_VREG, 4'd0, ALU_SUB, LD_W, WB_ALU, '0, 0, 3);
  add_case("pipe_lbu", OP0_SCALAR, OP1_STRIDE, 4'd9, ALU_ADD, LD_BU, WB_LOAD, LOAD_PATTERN, 0, 0);
  add_case("pipe_sra", OP0_VREG, OP1_VREG, 4'd0, ALU_SRA, LD_W, WB_ALU, '0, 0, 0);
endtask

`endif

// File: tb_vec_dpath.sv
// Testbench for the four-lane vector datapath slice
// LFSR operands, reference model, table loop and report

`timescale 1ns/1ps

module tb_vec_dpath
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
();

  logic clk;
  logic reset;
  logic stall;
  lane_vec_t vs0;
  lane_vec_t vs1;
  word_t rs0;
  word_t rs1;
  logic [IDX_W-1:0] v_idx;
  op0_sel_e op0_sel;
  op1_sel_e op1_sel;
  alu_fn_e alu_fn;
  load_fn_e load_fn;
  logic queue_en;
  logic queue_val;
  wb_sel_e wb_sel;
  lane_vec_t dmem_rdata;
  lane_vec_t dmem_addr;
  lane_vec_t dmem_wdata;
  lane_vec_t wb_data;

  `include "tb_vec_dpath_cases.svh"

  // Per-operation slots of one stream, at most three in flight
  lane_vec_t op_vs0[3];
  lane_vec_t op_vs1[3];
  word_t op_rs0[3];
  word_t op_rs1[3];
  lane_vec_t exp_addr[3];
  lane_vec_t exp_wb[3];
  bit op_ok[3];
  logic [31:0] lfsr_q;
  int n_pass;
  int n_fail;
  int cycle_count = 0;

  vec_dpath_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .vs0        (vs0),
    .vs1        (vs1),
    .rs0        (rs0),
    .rs1        (rs1),
    .v_idx      (v_idx),
    .op0_sel    (op0_sel),
    .op1_sel    (op1_sel),
    .alu_fn     (alu_fn),
    .load_fn    (load_fn),
    .queue_en   (queue_en),
    .queue_val  (queue_val),
    .wb_sel     (wb_sel),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .wb_data    (wb_data)
  );

  always #10 clk = ~clk;

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > 2000) begin
      $display("Timeout: simulation ran past 2000 cycles");
      $display(">>> FAIL");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Random words and reference model
  //--------------------------------------------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic word_t rand_word();
    word_t w;
    logic fb;
    w = '0;
    for (int k = 0; k < WORD_W; k++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic word_t ref_alu(word_t a, word_t b, alu_fn_e fn);
    logic [4:0] sh;
    sh = b[4:0];
    case (fn)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $signed(a) >>> sh;
      default:  return '0;
    endcase
  endfunction

  function automatic word_t ref_load(word_t w, load_fn_e fn);
    case (fn)
      LD_B:    return {{24{w[7]}}, w[7:0]};
      LD_BU:   return {24'd0, w[7:0]};
      LD_H:    return {{16{w[15]}}, w[15:0]};
      LD_HU:   return {16'd0, w[15:0]};
      default: return w;
    endcase
  endfunction

  // Draws operands for slot k and works out its expected outputs
  task automatic prepare_op(input int e, input int k);
    word_t a;
    word_t b;
    word_t elem;
    op_rs0[k] = rand_word();
    op_rs1[k] = rand_word();
    for (int i = 0; i < NUM_LANES; i++) begin
      op_vs0[k][i] = rand_word();
      op_vs1[k][i] = rand_word();
      case (cases[e].op0_sel)
        OP0_VREG:   a = op_vs0[k][i];
        OP0_SCALAR: a = op_rs0[k];
        default:    a = '0;
      endcase
      elem = {28'd0, cases[e].v_idx} * 4 + i;
      case (cases[e].op1_sel)
        OP1_VREG:   b = op_vs1[k][i];
        OP1_STRIDE: b = elem * op_rs1[k];
        default:    b = '0;
      endcase
      exp_addr[k][i] = ref_alu(a, b, cases[e].alu_fn);
      if (cases[e].wb_sel == WB_LOAD)
        exp_wb[k][i] = ref_load(cases[e].resp[i], cases[e].load_fn);
      else
        exp_wb[k][i] = exp_addr[k][i];
    end
    op_ok[k] = 1'b1;
  endtask

  //--------------------------------------------------------------------------
  // Checks and stimulus
  //--------------------------------------------------------------------------

  task automatic check_vec(input string what, input lane_vec_t exp, input lane_vec_t act,
                           input int k);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", what, exp, act);
      op_ok[k] = 1'b0;
    end
  endtask

  task automatic finish_test(input string name, input bit ok);
    if (ok) begin
      n_pass++;
      $display("Test %s: ok", name);
    end else begin
      n_fail++;
      $display("Test %s: FAILED", name);
    end
  endtask

  // Stall while the response waits in the hold register, then release
  task automatic hold_response(input int e, input int k);
    lane_vec_t held;
    stall <= 1'b1;
    queue_en <= 1'b1;
    for (int s = 0; s < cases[e].stall_cycles; s++) begin
      @(negedge clk);
      if (s == 0)
        held = wb_data;
      else
        check_vec({case_name[e], " wb_data during stall"}, held, wb_data, k);
      @(posedge clk);
      queue_en <= 1'b0;
      dmem_rdata <= {rand_word(), rand_word(), rand_word(), rand_word()};
    end
    // Held response goes to W at the next edge
    stall <= 1'b0;
    queue_val <= 1'b1;
  endtask

  // D, X and M fields of successive operations overlap by one cycle each
  task automatic run_stream(input int first, input int count);
    int e;
    for (int k = 0; k < count; k++)
      prepare_op(first + k, k);
    for (int c = 0; c <= count + 2; c++) begin
      @(posedge clk);
      queue_en <= 1'b0;
      queue_val <= 1'b0;
      if (c < count) begin
        e = first + c;
        vs0 <= op_vs0[c];
        vs1 <= op_vs1[c];
        rs0 <= op_rs0[c];
        rs1 <= op_rs1[c];
        v_idx <= cases[e].v_idx;
        op0_sel <= cases[e].op0_sel;
        op1_sel <= cases[e].op1_sel;
      end
      if (c >= 1 && c <= count)
        alu_fn <= cases[first + c - 1].alu_fn;
      if (c >= 2 && c <= count + 1) begin
        e = first + c - 2;
        load_fn <= cases[e].load_fn;
        wb_sel <= cases[e].wb_sel;
        dmem_rdata <= cases[e].resp;
        if (cases[e].stall_cycles > 0)
          hold_response(e, c - 2);
      end
      @(negedge clk);
      if (c >= 1 && c <= count) begin
        check_vec({case_name[first + c - 1], " dmem_addr"}, exp_addr[c - 1], dmem_addr, c - 1);
        check_vec({case_name[first + c - 1], " dmem_wdata"}, op_vs1[c - 1], dmem_wdata, c - 1);
      end
      if (c >= 3) begin
        check_vec({case_name[first + c - 3], " wb_data"}, exp_wb[c - 3], wb_data, c - 3);
        finish_test(case_name[first + c - 3], op_ok[c - 3]);
      end
    end
  endtask

  initial begin
    int i;
    lfsr_q = 32'h940c550e;
    n_pass = 0;
    n_fail = 0;
    clk = 1'b0;
    reset = 1'b1;
    stall = 1'b0;
    vs0 = '0;
    vs1 = '0;
    rs0 = '0;
    rs1 = '0;
    v_idx = '0;
    op0_sel = OP0_VREG;
    op1_sel = OP1_VREG;
    alu_fn = ALU_ADD;
    load_fn = LD_W;
    queue_en = 1'b0;
    queue_val = 1'b0;
    wb_sel = WB_ALU;
    dmem_rdata = '0;
    for (int k = 0; k < 3; k++)
      @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    op_ok[0] = 1'b1;
    check_vec("reset wb_data", '0, wb_data, 0);
    finish_test("reset", op_ok[0]);

    load_cases();
    i = 0;
    while (i < cases.size()) begin
      run_stream(i, cases[i].group);
      i += cases[i].group;
    end

    $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: vec_dpath_top.sv
// Top level of the four-lane vector datapath slice
// Connects execute, load queue and writeback stages

`timescale 1ns/1ps

module vec_dpath_top
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  // Decode stage operands and selects
  input  lane_vec_t        vs0,
  input  lane_vec_t        vs1,
  input  word_t            rs0,
  input  word_t            rs1,
  input  logic [IDX_W-1:0] v_idx,
  input  op0_sel_e         op0_sel,
  input  op1_sel_e         op1_sel,
  // Execute stage function
  input  alu_fn_e          alu_fn,
  // Memory stage controls
  input  load_fn_e         load_fn,
  input  logic             queue_en,
  input  logic             queue_val,
  input  wb_sel_e          wb_sel,
  // Data memory lanes
  input  lane_vec_t        dmem_rdata,
  output lane_vec_t        dmem_addr,
  output lane_vec_t        dmem_wdata,
  output lane_vec_t        wb_data
);

  lane_vec_t load_data_m;

  // The lane ALU result doubles as the memory request address
  vec_execute_stage i_execute (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .vs0          (vs0),
    .vs1          (vs1),
    .rs0          (rs0),
    .rs1          (rs1),
    .v_idx        (v_idx),
    .op0_sel      (op0_sel),
    .op1_sel      (op1_sel),
    .alu_fn       (alu_fn),
    .alu_result_x (dmem_addr),
    .wdata_x      (dmem_wdata)
  );

  vec_load_queue i_load_queue (
    .clk         (clk),
    .reset       (reset),
    .dmem_rdata  (dmem_rdata),
    .load_fn     (load_fn),
    .queue_en    (queue_en),
    .queue_val   (queue_val),
    .load_data_m (load_data_m)
  );

  vec_writeback i_writeback (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .alu_result_x (dmem_addr),
    .load_data_m  (load_data_m),
    .wb_sel       (wb_sel),
    .wb_data      (wb_data)
  );

endmodule

// File: vec_writeback.sv
// Memory stage register, writeback source select and writeback register

`timescale 1ns/1ps

module vec_writeback
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  lane_vec_t alu_result_x,
  input  lane_vec_t load_data_m,
  input  wb_sel_e   wb_sel,
  output lane_vec_t wb_data
);

  lane_vec_t alu_result_m;
  lane_vec_t wb_mux_m;

  // M <- X
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_result_m <= '0;
    end else if (!stall) begin
      alu_result_m <= alu_result_x;
    end
  end

  // Loads take the adjusted or queued response, everything else the ALU
  assign wb_mux_m = (wb_sel == WB_LOAD) ? load_data_m : alu_result_m;

  // W <- M
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_data <= '0;
    end else if (!stall) begin
      wb_data <= wb_mux_m;
    end
  end

endmodule

// File: vec_load_queue.sv
// Per-lane load response adjustment for word, byte and halfword loads,
// one-entry response hold register and the queue output select

`timescale 1ns/1ps

module vec_load_queue
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  lane_vec_t dmem_rdata,
  input  load_fn_e  load_fn,
  input  logic      queue_en,
  input  logic      queue_val,
  output lane_vec_t load_data_m
);

  lane_vec_t adj_m;
  lane_vec_t hold_q;

  // Subword extraction from the low end of each lane word
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      case (load_fn)
        LD_W: adj_m[i] = dmem_rdata[i];
        LD_B: adj_m[i] = {{(WORD_W-BYTE_W){dmem_rdata[i][BYTE_W-1]}},
                          dmem_rdata[i][BYTE_W-1:0]};
        LD_BU: adj_m[i] = {{(WORD_W-BYTE_W){1'b0}}, dmem_rdata[i][BYTE_W-1:0]};
        LD_H: adj_m[i] = {{(WORD_W-HALF_W){dmem_rdata[i][HALF_W-1]}},
                          dmem_rdata[i][HALF_W-1:0]};
        LD_HU: adj_m[i] = {{(WORD_W-HALF_W){1'b0}}, dmem_rdata[i][HALF_W-1:0]};
        default: adj_m[i] = dmem_rdata[i];
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Response hold
  //--------------------------------------------------------------------------

  // Keeps a response that arrives while the pipeline cannot take it
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_q <= '0;
    end else if (queue_en) begin
      hold_q <= adj_m;
    end
  end

  assign load_data_m = queue_val ? hold_q : adj_m;

endmodule

// File: vec_execute_stage.sv
// Decode operand selection with scalar broadcast and stride offsets,
// execute stage register and the array of lane ALUs

`timescale 1ns/1ps

module vec_execute_stage
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  lane_vec_t        vs0,
  input  lane_vec_t        vs1,
  input  word_t            rs0,
  input  word_t            rs1,
  input  logic [IDX_W-1:0] v_idx,
  input  op0_sel_e         op0_sel,
  input  op1_sel_e         op1_sel,
  input  alu_fn_e          alu_fn,
  output lane_vec_t        alu_result_x,
  output lane_vec_t        wdata_x
);

  lane_vec_t scalar_d;
  lane_vec_t stride_d;
  lane_vec_t op0_d;
  lane_vec_t op1_d;
  lane_vec_t op0_x;
  lane_vec_t op1_x;

  //--------------------------------------------------------------------------
  // Decode stage
  //--------------------------------------------------------------------------

  // Same scalar in every lane
  assign scalar_d = {NUM_LANES{rs0}};

  // Element number of lane i is v_idx * NUM_LANES + i, scaled by the stride
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_stride
    assign stride_d[i] = (word_t'(v_idx) * word_t'(NUM_LANES) + word_t'(i)) * rs1;
  end

  always_comb begin
    case (op0_sel)
      OP0_VREG:   op0_d = vs0;
      OP0_SCALAR: op0_d = scalar_d;
      OP0_ZERO:   op0_d = '0;
      default:    op0_d = '0;
    endcase
  end

  always_comb begin
    case (op1_sel)
      OP1_VREG:   op1_d = vs1;
      OP1_STRIDE: op1_d = stride_d;
      OP1_ZERO:   op1_d = '0;
      default:    op1_d = '0;
    endcase
  end

  //--------------------------------------------------------------------------
  // X <- D
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      op0_x   <= '0;
      op1_x   <= '0;
      wdata_x <= '0;
    end else if (!stall) begin
      op0_x   <= op0_d;
      op1_x   <= op1_d;
      // Store data always comes from the second vector operand
      wdata_x <= vs1;
    end
  end

  // Execute stage lanes, all sharing one function code
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_alu i_alu (
      .a      (op0_x[i]),
      .b      (op1_x[i]),
      .fn     (alu_fn),
      .result (alu_result_x[i])
    );
  end

endmodule

// File: lane_alu.sv
// Single lane arithmetic and logic unit

`timescale 1ns/1ps

module lane_alu
  import vec_cfg_pkg::*;
  import vec_ctrl_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_fn_e fn,
  output word_t   result
);

  // Only the low five bits of b act as shift amount
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (fn)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      // Compares give 1 or 0 in the full word
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      default:  result = '0;
    endcase
  end

endmodule

// File: vec_ctrl_pkg.sv
// Select and function codes for the decode, execute, memory and
// writeback stages of the vector slice

package vec_ctrl_pkg;

  // Decode stage, operand 0 source
  typedef enum logic [1:0] {
    OP0_VREG   = 2'd0,
    OP0_SCALAR = 2'd1,
    OP0_ZERO   = 2'd2
  } op0_sel_e;

  // Decode stage, operand 1 source
  typedef enum logic [1:0] {
    OP1_VREG   = 2'd0,
    OP1_STRIDE = 2'd1,
    OP1_ZERO   = 2'd2
  } op1_sel_e;

  // Execute stage, lane function
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_fn_e;

  // Memory stage, load response adjustment
  typedef enum logic [2:0] {
    LD_W  = 3'd0,
    LD_B  = 3'd1,
    LD_BU = 3'd2,
    LD_H  = 3'd3,
    LD_HU = 3'd4
  } load_fn_e;

  // Memory stage, writeback source
  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_LOAD = 1'b1
  } wb_sel_e;

endpackage

// File: vec_cfg_pkg.sv
// Lane count, word width and element index width
// Lane word and lane vector types shared by every stage

package vec_cfg_pkg;

  // Slice geometry
  localparam int NUM_LANES = 4;
  localparam int WORD_W    = 32;
  localparam int IDX_W     = 4;

  // Subword sizes for load adjustment
  localparam int BYTE_W = 8;
  localparam int HALF_W = 16;

  // One lane word
  typedef logic [WORD_W-1:0] word_t;

  // All lanes side by side, lane 0 in the low word
  typedef word_t [NUM_LANES-1:0] lane_vec_t;

endpackage
